//--- flist.f
+incdir+source
source/daq_frame_pkg.sv
source/crc16_word.sv
source/frame_lane.sv
source/frame_proc_fsm.sv
source/tmr_voter.sv
source/daq_frame_tx.sv
verif/tb_daq_frame_tx.sv

//--- Makefile
SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)

all: run

obj_dir/Vtb_daq_frame_tx: flist.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_daq_frame_tx -f flist.f

run: obj_dir/Vtb_daq_frame_tx
	./obj_dir/Vtb_daq_frame_tx | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- verif/tb_daq_frame_tx.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module tb_daq_frame_tx
	import daq_frame_pkg::*;
();

	localparam int NUM_PKTS       = 40;
	localparam int RESET_PKT      = 20; // Cut short by an arst pulse
	localparam int TIMEOUT_CYCLES = NUM_PKTS * 30 + 200;

	localparam lane_out_t IDLE_OUT = '{word: {`DAQ_D16_2, `DAQ_K28_5}, char_k: 2'b01};
	localparam lane_out_t SOP_OUT  = '{word: {`DAQ_PRMBL, `DAQ_K27_7}, char_k: 2'b01};
	localparam lane_out_t PRE_OUT  = '{word: {`DAQ_PRMBL, `DAQ_PRMBL}, char_k: 2'b00};
	localparam lane_out_t SOF_OUT  = '{word: {`DAQ_SOF_BYTE, `DAQ_PRMBL}, char_k: 2'b00};
	localparam lane_out_t EOP_OUT  = '{word: {`DAQ_K23_7, `DAQ_K29_7}, char_k: 2'b11};
	localparam lane_out_t EXT_OUT  = '{word: {`DAQ_K23_7, `DAQ_K23_7}, char_k: 2'b11};

	// Output word and ack expected in one clock cycle
	typedef struct packed {
		int        due;
		lane_out_t out;
		logic      ack;
	} exp_entry_t;

	logic       usr_clk_wordwise = 1'b0;
	logic       arst;
	tx_word_t   txd_i;
	logic       txd_vld_i;
	logic       tx_ack_o;
	lane_out_t  tx_word_o;

	int         seed = 14635;
	int         cyc = 0;
	logic       chk_en = 1'b0;
	lane_out_t  exp_out = IDLE_OUT;
	logic       exp_ack = 1'b0;
	exp_entry_t exp_q[$];
	int         pkts_sent = 0;
	int         word_errors = 0;
	int         ack_errors = 0;
	int         other_errors = 0;

	daq_frame_tx i_daq_frame_tx (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.tx_word_o        (tx_word_o)
	);

	always #10 usr_clk_wordwise = ~usr_clk_wordwise;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// CRC-CCITT, high byte of the word first
	function automatic crc_t crc_ccitt_word(input crc_t crc_in, input tx_word_t data);
		crc_t crc;
		int   b;
		int   k;
		crc = crc_in;
		for (b = 1; b >= 0; b--)
		begin
			crc = crc ^ {data[b*8 +: 8], 8'h00};
			for (k = 0; k < 8; k++)
			begin
				if (crc[15])
					crc = {crc[14:0], 1'b0} ^ `DAQ_CRC_POLY;
				else
					crc = {crc[14:0], 1'b0};
			end
		end
		return crc;
	endfunction

	function automatic void expect_word(input int due, input lane_out_t out, input logic ack);
		exp_entry_t e;
		e.due = due;
		e.out = out;
		e.ack = ack;
		exp_q.push_back(e);
	endfunction

	// Idle unless the queue holds a word for this cycle
	always @(posedge usr_clk_wordwise)
	begin
		cyc    <= cyc + 1;
		chk_en <= (cyc >= 2);
		exp_out <= IDLE_OUT;
		exp_ack <= 1'b0;
		if (exp_q.size() > 0)
		begin
			if (exp_q[0].due == cyc)
			begin
				exp_out <= exp_q[0].out;
				exp_ack <= exp_q[0].ack;
				void'(exp_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_idle_in_reset: assert property (@(posedge usr_clk_wordwise)
		(chk_en && arst) |-> (tx_word_o == IDLE_OUT && !tx_ack_o))
		else
		begin
			other_errors++;
			$display("ERROR %0t ns: output %h/%b not idle or ack high during arst", $time,
				$sampled(tx_word_o.word), $sampled(tx_word_o.char_k));
		end

	a_word_match: assert property (@(posedge usr_clk_wordwise)
		(chk_en && !arst) |-> (tx_word_o == exp_out))
		else
		begin
			word_errors++;
			$display("ERROR %0t ns: tx_word_o %h/%b, expected %h/%b", $time,
				$sampled(tx_word_o.word), $sampled(tx_word_o.char_k),
				$sampled(exp_out.word), $sampled(exp_out.char_k));
		end

	a_ack_match: assert property (@(posedge usr_clk_wordwise)
		(chk_en && !arst) |-> (tx_ack_o == exp_ack))
		else
		begin
			ack_errors++;
			$display("ERROR %0t ns: tx_ack_o %b, expected %b", $time,
				$sampled(tx_ack_o), $sampled(exp_ack));
		end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic pulse_reset();
		arst      <= 1'b1;
		txd_vld_i <= 1'b0;
		exp_q.delete(); // Packet abandoned, line returns to idle
		repeat (3) @(posedge usr_clk_wordwise);
		arst <= 1'b0;
		repeat (8) @(posedge usr_clk_wordwise);
	endtask

	// Called right after a rising edge, returns right after one
	task automatic send_packet(input int len, input int cut_at);
		int          e0;
		int          i;
		logic [31:0] rnd;
		tx_word_t    data;
		crc_t        crc;
		e0 = cyc;
		txd_vld_i <= 1'b1;
		expect_word(e0 + 2, SOP_OUT, 1'b0);
		for (i = 0; i < `DAQ_PREAMBLE_WORDS; i++)
			expect_word(e0 + 3 + i, PRE_OUT, i == `DAQ_PREAMBLE_WORDS - 1); // Ack before SOF
		expect_word(e0 + 3 + `DAQ_PREAMBLE_WORDS, SOF_OUT, 1'b0);
		do
			@(posedge usr_clk_wordwise);
		while (!tx_ack_o);
		crc = `DAQ_CRC_INIT;
		for (i = 0; i < len; i++)
		begin
			if (i == cut_at)
			begin
				pulse_reset();
				return;
			end
			rnd  = $random(seed);
			data = rnd[15:0];
			txd_i <= data;
			crc = crc_ccitt_word(crc, data);
			expect_word(cyc + 1, lane_out_t'{word: data, char_k: 2'b00}, 1'b0);
			@(posedge usr_clk_wordwise);
		end
		txd_vld_i <= 1'b0;
		expect_word(cyc + 1, lane_out_t'{word: crc, char_k: 2'b00}, 1'b0);
		expect_word(cyc + 2, EOP_OUT, 1'b0);
		expect_word(cyc + 3, EXT_OUT, 1'b0);
		pkts_sent++;
	endtask

	initial
	begin
		int len;
		int gap;
		int cut;
		int p;
		arst      = 1'b1;
		txd_vld_i = 1'b0;
		txd_i     = '0;
		repeat (16) @(posedge usr_clk_wordwise);
		arst <= 1'b0;
		repeat (8) @(posedge usr_clk_wordwise);
		for (p = 0; p < NUM_PKTS; p++)
		begin
			len = 1 + int'($unsigned($random(seed)) % 16);
			gap = 3 + int'($unsigned($random(seed)) % 4); // 3 is back to back
			cut = -1;
			if (p == 0)
				len = 1;
			if (p == RESET_PKT)
			begin
				if (len < 4)
					len = 4;
				cut = len / 2;
			end
			send_packet(len, cut);
			repeat (gap) @(posedge usr_clk_wordwise);
		end
		repeat (6) @(posedge usr_clk_wordwise);
		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("Run ended with %0d expected words never seen on tx_word_o", exp_q.size());
		end
		$display("Packets: %0d, word errors: %0d, ack errors: %0d, other errors: %0d",
			pkts_sent, word_errors, ack_errors, other_errors);
		if (word_errors + ack_errors + other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		while (cyc < TIMEOUT_CYCLES)
			@(posedge usr_clk_wordwise);
		$display("Timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- source/daq_frame_tx.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module daq_frame_tx
	import daq_frame_pkg::*;
(
	input  logic      usr_clk_wordwise,
	input  logic      arst,
	input  tx_word_t  txd_i,
	input  logic      txd_vld_i,
	output logic      tx_ack_o,
	output lane_out_t tx_word_o
);

	logic       rst;
	logic [3:0] rst_sync;
	lane_ctrl_t lane_ctrl;
	lane_out_t  lane_out [`DAQ_TMR_LANES];

	//////////////////////////////////////////////////////////////////////
	// Reset synchronizer
	//////////////////////////////////////////////////////////////////////

	// Asserts at once, releases after four clocks
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			rst_sync <= '1;
		else
			rst_sync <= {rst_sync[2:0], 1'b0};
	end

	assign rst = rst_sync[3];

	frame_proc_fsm i_frame_proc_fsm (
		.usr_clk_wordwise (usr_clk_wordwise),
		.rst_i            (rst),
		.txd_vld_i        (txd_vld_i),
		.lane_ctrl_o      (lane_ctrl),
		.tx_ack_o         (tx_ack_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Triplicated word datapath
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `DAQ_TMR_LANES; g++)
	begin : g_lane
		frame_lane i_frame_lane (
			.usr_clk_wordwise (usr_clk_wordwise),
			.rst_i            (rst),
			.txd_i            (txd_i),
			.lane_ctrl_i      (lane_ctrl),
			.lane_o           (lane_out[g])
		);
	end

	tmr_voter i_tmr_voter (
		.usr_clk_wordwise (usr_clk_wordwise),
		.lanes_i          (lane_out),
		.voted_o          (tx_word_o) // Straight to the transceiver
	);

endmodule

//--- source/tmr_voter.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module tmr_voter
	import daq_frame_pkg::*;
(
	input  logic      usr_clk_wordwise,
	input  lane_out_t lanes_i [`DAQ_TMR_LANES],
	output lane_out_t voted_o
);

	//////////////////////////////////////////////////////////////////////
	// Two-of-three majority, bit by bit
	//////////////////////////////////////////////////////////////////////

	// Word and K flags voted together
	assign voted_o = (lanes_i[0] & lanes_i[1])
		| (lanes_i[1] & lanes_i[2])
		| (lanes_i[0] & lanes_i[2]);

	default clocking cb_vote @(posedge usr_clk_wordwise);
	endclocking

	// Lanes share control and data, so any mismatch means an upset in one lane
	a_lanes_agree: assert property (
		(lanes_i[0] == lanes_i[1]) && (lanes_i[1] == lanes_i[2]))
		else $error("TMR lanes disagree: %h %h %h", lanes_i[0], lanes_i[1], lanes_i[2]);

endmodule

//--- source/frame_proc_fsm.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module frame_proc_fsm
	import daq_frame_pkg::*;
(
	input  logic       usr_clk_wordwise,
	input  logic       rst_i,
	input  logic       txd_vld_i,
	output lane_ctrl_t lane_ctrl_o,
	output logic       tx_ack_o
);

	frm_state_t state_q;   // Registered state
	frm_state_t state;     // Effective state this cycle
	frm_state_t state_nxt;
	logic [3:0] prmbl_cnt;

	// Data ends in the very cycle valid drops, so CRC goes out right behind it
	always_comb
	begin
		if (state_q == ST_DATA && !txd_vld_i)
			state = ST_CRC;
		else
			state = state_q;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (txd_vld_i)
					state_nxt = ST_SOP;
			end
			ST_SOP:      state_nxt = ST_PREAMBLE;
			ST_PREAMBLE:
			begin
				if (prmbl_cnt == 4'(`DAQ_PREAMBLE_WORDS - 1))
					state_nxt = ST_SOF;
			end
			ST_SOF:      state_nxt = ST_DATA;
			ST_DATA:     state_nxt = ST_DATA; // Held while valid stays high
			ST_CRC:      state_nxt = ST_EOP;
			ST_EOP:      state_nxt = ST_EXTEND;
			ST_EXTEND:   state_nxt = ST_IDLE;
			default:     state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
		begin
			state_q   <= ST_IDLE;
			prmbl_cnt <= '0;
		end
		else
		begin
			state_q <= state_nxt;
			if (state == ST_PREAMBLE)
				prmbl_cnt <= prmbl_cnt + 4'd1; // Preamble words sent so far
			else
				prmbl_cnt <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane control decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		lane_ctrl_o = '{rom_sel: ROM_IDLE, clr_crc: 1'b0, crc_calc: 1'b0, send_crc: 1'b0};
		case (state)
			ST_SOP:      lane_ctrl_o.rom_sel = ROM_SOP_PRE;
			ST_PREAMBLE: lane_ctrl_o.rom_sel = ROM_PREAMBLE;
			ST_SOF:
			begin
				lane_ctrl_o.rom_sel = ROM_SOF_PRE;
				lane_ctrl_o.clr_crc = 1'b1; // Fresh CRC for the coming data
			end
			ST_DATA:     lane_ctrl_o.crc_calc = 1'b1;
			ST_CRC:      lane_ctrl_o.send_crc = 1'b1;
			ST_EOP:      lane_ctrl_o.rom_sel = ROM_EOP;
			ST_EXTEND:   lane_ctrl_o.rom_sel = ROM_EXTEND;
			default:     lane_ctrl_o.rom_sel = ROM_IDLE;
		endcase
	end

	// Host starts data on the next clock
	assign tx_ack_o = (state == ST_SOF);

	// One acknowledge pulse per packet, host data follows right behind it
	a_ack_single: assert property (@(posedge usr_clk_wordwise) disable iff (rst_i)
		tx_ack_o |=> (!tx_ack_o && txd_vld_i))
		else $error("tx_ack_o high twice in a row or no host data after it");

endmodule

//--- source/frame_lane.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module frame_lane
	import daq_frame_pkg::*;
(
	input  logic       usr_clk_wordwise,
	input  logic       rst_i,
	input  tx_word_t   txd_i,
	input  lane_ctrl_t lane_ctrl_i,
	output lane_out_t  lane_o
);

	// K28.5 then D16.2
	localparam lane_out_t IDLE_OUT = '{word: {`DAQ_D16_2, `DAQ_K28_5}, char_k: 2'b01};

	crc_t      crc;
	lane_out_t rom_word;

	crc16_word i_crc16_word (
		.usr_clk_wordwise (usr_clk_wordwise),
		.rst_i            (rst_i),
		.clr_i            (lane_ctrl_i.clr_crc),
		.calc_i           (lane_ctrl_i.crc_calc),
		.data_i           (txd_i),
		.crc_o            (crc)
	);

	//////////////////////////////////////////////////////////////////////
	// Ordered-set ROM with matching K flags
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (lane_ctrl_i.rom_sel)
			ROM_SOP_PRE:
				rom_word = '{word: {`DAQ_PRMBL, `DAQ_K27_7}, char_k: 2'b01};
			ROM_PREAMBLE:
				rom_word = '{word: {`DAQ_PRMBL, `DAQ_PRMBL}, char_k: 2'b00};
			ROM_SOF_PRE:
				rom_word = '{word: {`DAQ_SOF_BYTE, `DAQ_PRMBL}, char_k: 2'b00};
			ROM_EOP: // EOP plus first extend
				rom_word = '{word: {`DAQ_K23_7, `DAQ_K29_7}, char_k: 2'b11};
			ROM_EXTEND:
				rom_word = '{word: {`DAQ_K23_7, `DAQ_K23_7}, char_k: 2'b11};
			default:
				rom_word = IDLE_OUT;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	// CRC wins over data, data over ordered sets
	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
			lane_o <= IDLE_OUT; // Line idles through reset
		else if (lane_ctrl_i.send_crc)
			lane_o <= '{word: crc, char_k: 2'b00};
		else if (lane_ctrl_i.crc_calc)
			lane_o <= '{word: txd_i, char_k: 2'b00}; // Host data passes unchanged
		else
			lane_o <= rom_word;
	end

endmodule

//--- source/crc16_word.sv
`timescale 1ns/100ps
`include "daq_frame_params.svh"

module crc16_word
	import daq_frame_pkg::*;
(
	input  logic     usr_clk_wordwise,
	input  logic     rst_i,
	input  logic     clr_i,
	input  logic     calc_i,
	input  tx_word_t data_i,
	output crc_t     crc_o
);

	// Sixteen serial CRC steps folded into one clock
	function automatic crc_t crc_step(input crc_t crc_in, input tx_word_t data);
		crc_t c;
		c = crc_in;
		for (int i = 15; i >= 0; i--)
		begin
			if (c[15] ^ data[i])
				c = {c[14:0], 1'b0} ^ `DAQ_CRC_POLY;
			else
				c = {c[14:0], 1'b0};
		end
		return c;
	endfunction

	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
			crc_o <= `DAQ_CRC_INIT;
		else if (clr_i)
			crc_o <= `DAQ_CRC_INIT;
		else if (calc_i)
			crc_o <= crc_step(crc_o, data_i);
	end

endmodule

//--- source/daq_frame_pkg.sv
package daq_frame_pkg;

	typedef logic [15:0] tx_word_t; // Low byte goes first on the line
	typedef logic [1:0]  char_k_t;  // Bit 0 flags the low byte
	typedef logic [15:0] crc_t;
	typedef logic [2:0]  rom_sel_t;

	// Ordered-set selector codes
	localparam rom_sel_t ROM_IDLE    = 3'd0;
	localparam rom_sel_t ROM_SOP_PRE = 3'd1; // SOP plus first preamble octet
	localparam rom_sel_t ROM_PREAMBLE = 3'd2;
	localparam rom_sel_t ROM_SOF_PRE = 3'd3; // Preamble octet plus SOF
	localparam rom_sel_t ROM_EOP     = 3'd5;
	localparam rom_sel_t ROM_EXTEND  = 3'd6;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SOP,
		ST_PREAMBLE,
		ST_SOF,
		ST_DATA,
		ST_CRC,
		ST_EOP,
		ST_EXTEND
	} frm_state_t;

	// Control from the frame FSM, shared by all lanes
	typedef struct packed {
		rom_sel_t rom_sel;
		logic     clr_crc;
		logic     crc_calc; // Data word accepted this cycle
		logic     send_crc;
	} lane_ctrl_t;

	typedef struct packed {
		tx_word_t word;
		char_k_t  char_k;
	} lane_out_t;

endpackage

//--- source/daq_frame_params.svh
`ifndef DAQ_FRAME_PARAMS_SVH
`define DAQ_FRAME_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Ordered-set octets
//////////////////////////////////////////////////////////////////////

// Comma, first octet of every idle word
`define DAQ_K28_5 8'hBC
`define DAQ_D16_2 8'h50
// Start of packet /S/
`define DAQ_K27_7 8'hFB
// End of packet /T/
`define DAQ_K29_7 8'hFD
// Carrier extend /R/
`define DAQ_K23_7 8'hF7
`define DAQ_PRMBL 8'h55
`define DAQ_SOF_BYTE 8'hD5

// Plain preamble words between SOP and SOF
`define DAQ_PREAMBLE_WORDS 2

// CRC-16 CCITT, MSB first
`define DAQ_CRC_POLY 16'h1021
`define DAQ_CRC_INIT 16'hFFFF

// Redundant datapath lanes
`define DAQ_TMR_LANES 3

`endif
